// ==== hw/lc3b_types.sv ====
`default_nettype none

package lc3b_types;

	typedef logic [15:0] lc3b_word;      // instruction word, all zeros is a nop BR used as bubble
	typedef logic [2:0]  lc3b_reg;       // register index for dr / sr1 / sr2 fields
	typedef logic [2:0]  lc3b_nzp;       // condition codes n z p
	typedef logic [2:0]  shadow_cnt_t;   // countdown for the control-transfer shadow

	typedef enum logic [3:0]
	{
		op_br   = 4'b0000, // conditional branch
		op_add  = 4'b0001,
		op_ldb  = 4'b0010, // load byte
		op_stb  = 4'b0011, // store byte
		op_jsr  = 4'b0100, // jsr / jsrr
		op_and  = 4'b0101,
		op_ldr  = 4'b0110, // load word
		op_str  = 4'b0111, // store word
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010, // load indirect
		op_sti  = 4'b1011, // store indirect
		op_jmp  = 4'b1100, // jmp / ret
		op_shf  = 4'b1101, // shifts
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// bubbles plus the squash slot that follow a BR / JMP / JSR / TRAP
	localparam shadow_cnt_t SHADOW_LEN = 3'd5;

endpackage : lc3b_types

`default_nettype wire

// ==== hw/dep_decode.sv ====
`default_nettype none

module dep_decode
(
	input  lc3b_types::lc3b_word ir,
	output logic                 produces_dr, // writes a destination register
	output logic                 need_sr1,    // reads [8:6]
	output logic                 need_sr2,    // reads [2:0]
	output logic                 need_hsr     // store source held in [11:9]
);

	import lc3b_types::*;

	lc3b_opcode op;

	assign op = lc3b_opcode'(ir[15:12]); // opcode field

	always_comb
	begin
		produces_dr = 1'b0;
		need_sr1    = 1'b0;
		need_sr2    = 1'b0;
		need_hsr    = 1'b0;
		case (op)
			op_add, op_and:
			begin
				produces_dr = 1'b1;
				need_sr1    = 1'b1;
				need_sr2    = ~ir[5]; // register mode only
			end
			op_not, op_shf, op_ldb, op_ldr, op_ldi:
			begin
				produces_dr = 1'b1;
				need_sr1    = 1'b1; // source or base register
			end
			op_stb, op_str, op_sti:
			begin
				need_sr1 = 1'b1; // base register
				need_hsr = 1'b1; // data comes from the dr field
			end
			op_jsr:
			begin
				produces_dr = 1'b1;   // link into r7
				need_sr1    = ~ir[11]; // jsrr reads the base
			end
			op_jmp:  need_sr1 = 1'b1; // target in base register
			op_lea:  produces_dr = 1'b1;
			op_trap: produces_dr = 1'b1; // link into r7
			default: ; // br and rti touch no gpr
		endcase
	end

endmodule : dep_decode

`default_nettype wire

// ==== hw/branch_eval.sv ====
`default_nettype none

module branch_eval
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 cc_we,         // condition code write strobe
	input  lc3b_types::lc3b_nzp  cc_in,
	input  lc3b_types::lc3b_word id_ex_ir,
	output logic                 branch_enable  // BR in ID/EX is taken
);

	import lc3b_types::*;

	lc3b_nzp    nzp_q;    // current condition codes
	lc3b_opcode idex_op;
	lc3b_nzp    br_mask;  // nzp field of the branch

	assign idex_op = lc3b_opcode'(id_ex_ir[15:12]);
	assign br_mask = id_ex_ir[11:9];

	// cc writes land even while the pipe is frozen
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			nzp_q <= '0;
		else if (cc_we)
			nzp_q <= cc_in;
	end

	// taken when any requested flag is currently set
	assign branch_enable = (idex_op == op_br) && |(br_mask & nzp_q);

endmodule : branch_eval

`default_nettype wire

// ==== hw/bubbler.sv ====
`default_nettype none

module bubbler
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 flow,          // pipeline advances this edge
	input  lc3b_types::lc3b_word if_id_ir,
	input  lc3b_types::lc3b_word id_ex_ir,
	input  logic                 branch_enable, // BR in ID/EX is taken
	output logic                 gen_bubble,    // hold IF/ID and feed a nop to ID/EX
	output logic                 squash_id      // kill the instruction in decode
);

	import lc3b_types::*;

	lc3b_opcode  ifid_op, idex_op, last_op;
	lc3b_reg     load_dr;        // destination of the load in ID/EX
	logic        ifid_sr1, ifid_sr2, ifid_hsr;
	logic        idex_dr;
	logic        is_load;
	logic        is_xfer;        // pc-changing op sitting in IF/ID

	shadow_cnt_t cnt_q;          // shadow countdown
	shadow_cnt_t cnt_next;
	logic        cnt_load;
	logic        cnt_set;        // 1 = reload SHADOW_LEN, 0 = decrement
	logic        be_q;           // decision of the BR as the shadow opens
	lc3b_word    last_ir_q;      // last word seen in decode
	logic        last_load;

	dep_decode ifid_deps
	(
		.ir          (if_id_ir),
		.produces_dr (),
		.need_sr1    (ifid_sr1),
		.need_sr2    (ifid_sr2),
		.need_hsr    (ifid_hsr)
	);

	dep_decode idex_deps
	(
		.ir          (id_ex_ir),
		.produces_dr (idex_dr),
		.need_sr1    (),
		.need_sr2    (),
		.need_hsr    ()
	);

	assign ifid_op  = lc3b_opcode'(if_id_ir[15:12]);
	assign idex_op  = lc3b_opcode'(id_ex_ir[15:12]);
	assign last_op  = lc3b_opcode'(last_ir_q[15:12]);
	assign load_dr  = id_ex_ir[11:9];
	assign is_load  = idex_dr && (idex_op == op_ldb || idex_op == op_ldi || idex_op == op_ldr);
	assign is_xfer  = (if_id_ir != '0) &&
		(ifid_op == op_br || ifid_op == op_jmp || ifid_op == op_jsr || ifid_op == op_trap);
	assign cnt_next = cnt_set ? SHADOW_LEN : shadow_cnt_t'(cnt_q - 3'd1);

	always_comb
	begin
		gen_bubble = 1'b0;
		squash_id  = 1'b0;
		cnt_load   = 1'b0;
		cnt_set    = 1'b0;
		last_load  = 1'b1;

		// one bubble covers load-use since data is ready a stage later
		if (is_load)
		begin
			if (ifid_hsr && (if_id_ir[11:9] == load_dr || if_id_ir[8:6] == load_dr))
				gen_bubble = 1'b1; // store data or base depends on the load
			if (ifid_sr1 && if_id_ir[8:6] == load_dr)
				gen_bubble = 1'b1;
			if (ifid_sr2 && if_id_ir[2:0] == load_dr)
				gen_bubble = 1'b1;
		end

		// control-transfer shadow
		if (cnt_q == '0 && is_xfer)
		begin
			cnt_load = 1'b1; // start the countdown
			cnt_set  = 1'b1;
		end
		else if (cnt_q > 3'd1)
		begin
			cnt_load   = 1'b1; // counting down
			gen_bubble = 1'b1;
			last_load  = 1'b0; // keep the transfer op for the final decision
		end
		else if (cnt_q == 3'd1)
		begin
			cnt_load = 1'b1; // last step back to zero
			if (last_op == op_br)
				squash_id = be_q;  // only a taken branch kills decode
			else
				squash_id = 1'b1;  // jmp / jsr / trap always redirect
		end

		// lea gets the same countdown
		if (cnt_q == '0 && last_op == op_lea)
		begin
			cnt_load = 1'b1;
			cnt_set  = 1'b1;
		end

		if (last_op == op_lea && cnt_q != '0)
		begin
			gen_bubble = 1'b1;
			last_load  = 1'b0;
			cnt_load   = 1'b1;
			cnt_set    = 1'b0; // decrement
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cnt_q     <= '0;
			be_q      <= 1'b0;
			last_ir_q <= '0;
		end
		else if (flow)
		begin
			if (cnt_q == SHADOW_LEN)
				be_q <= branch_enable; // transfer sits in ID/EX on the first shadow cycle
			if (cnt_load)
				cnt_q <= cnt_next;
			if (last_load)
				last_ir_q <= if_id_ir; // frozen during shadow bubbles
		end
	end

	// counter only ever reloads to SHADOW_LEN and then counts down
	a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n) cnt_q <= SHADOW_LEN);

	// squash belongs to the last slot of a shadow
	a_squash_slot: assert property (@(posedge clk) disable iff (!rst_n)
		squash_id |-> cnt_q == 3'd1);

	// cleared state and nop latches leave nothing to stall on
	a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !gen_bubble && !squash_id);

endmodule : bubbler

`default_nettype wire

// ==== hw/stage_regs.sv ====
`default_nettype none

module stage_regs
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 flow,       // advance enable
	input  logic                 gen_bubble, // hold IF/ID, nop into ID/EX
	input  logic                 squash_id,  // drop decode, nop into ID/EX
	input  lc3b_types::lc3b_word fetch_ir,   // word from fetch
	output lc3b_types::lc3b_word if_id_ir,
	output lc3b_types::lc3b_word id_ex_ir
);

	// IF/ID latch
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			if_id_ir <= '0;
		else if (flow && !gen_bubble)
			if_id_ir <= fetch_ir; // fetch re-presents the word while held
	end

	// ID/EX latch
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			id_ex_ir <= '0;
		else if (flow)
		begin
			if (gen_bubble || squash_id)
				id_ex_ir <= '0; // all zero is BR with empty nzp, a nop
			else
				id_ex_ir <= if_id_ir;
		end
	end

	// the held decode word must survive the bubble edge untouched
	a_hold_on_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		flow && gen_bubble |=> $stable(if_id_ir));

endmodule : stage_regs

`default_nettype wire

// ==== hw/hazard_pipe.sv ====
`default_nettype none

module hazard_pipe
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 flow,      // whole slice advances when high
	input  logic                 cc_we,     // condition code strobe
	input  lc3b_types::lc3b_nzp  cc_in,
	input  lc3b_types::lc3b_word fetch_ir,
	output lc3b_types::lc3b_word if_id_ir,
	output lc3b_types::lc3b_word id_ex_ir,
	output logic                 fetch_hold, // bubble, fetch repeats its word
	output logic                 squash_id
);

	logic branch_enable; // BR in ID/EX taken

	stage_regs u_stage_regs
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.flow       (flow),
		.gen_bubble (fetch_hold),
		.squash_id  (squash_id),
		.fetch_ir   (fetch_ir),
		.if_id_ir   (if_id_ir),
		.id_ex_ir   (id_ex_ir)
	);

	branch_eval u_branch_eval
	(
		.clk           (clk),
		.rst_n         (rst_n),
		.cc_we         (cc_we),
		.cc_in         (cc_in),
		.id_ex_ir      (id_ex_ir),
		.branch_enable (branch_enable)
	);

	bubbler u_bubbler
	(
		.clk           (clk),
		.rst_n         (rst_n),
		.flow          (flow),
		.if_id_ir      (if_id_ir),
		.id_ex_ir      (id_ex_ir),
		.branch_enable (branch_enable),
		.gen_bubble    (fetch_hold), // same level goes to fetch and the latches
		.squash_id     (squash_id)
	);

endmodule : hazard_pipe

`default_nettype wire

// ==== tb/tb_hazard_pipe.sv ====
`default_nettype none

module tb_hazard_pipe;

	import lc3b_types::*;

	localparam int NUM_CYCLES = 3000;

	logic        clk;
	logic        rst_n;
	logic        flow;
	logic        cc_we;
	lc3b_nzp     cc_in;
	lc3b_word    fetch_ir;
	lc3b_word    if_id_ir;
	lc3b_word    id_ex_ir;
	logic        fetch_hold;
	logic        squash_id;
	logic [15:0] lfsr_q;                          // random source
	lc3b_word    model_ifid, model_idex, model_last;
	shadow_cnt_t model_cnt;                       // shadow countdown
	logic        model_be_q;                      // branch decision at the first shadow cycle
	lc3b_nzp     model_nzp;
	logic        exp_bubble, exp_squash, exp_be, exp_start, exp_hold_last, exp_hazard;
	int          n_load_use, n_shadow, n_lea, n_frozen; // scenario counters

	hazard_pipe uut
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.flow       (flow),
		.cc_we      (cc_we),
		.cc_in      (cc_in),
		.fetch_ir   (fetch_ir),
		.if_id_ir   (if_id_ir),
		.id_ex_ir   (id_ex_ir),
		.fetch_hold (fetch_hold),
		.squash_id  (squash_id)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset, the checked cycles and some slack
	initial
	begin
		#((NUM_CYCLES + 20) * 10);
		$display("timeout: the run did not finish in the expected time");
		$display("test failed");
		$fatal(1, "watchdog expired");
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr_q = lfsr_next(lfsr_q); // one step per bit
			v      = {v[14:0], lfsr_q[0]};
		end
	endtask

	// does the word read its [8:6] field
	function automatic logic reads_base(input lc3b_word w);
		case (lc3b_opcode'(w[15:12]))
			op_add, op_and, op_not, op_shf, op_ldb, op_ldr, op_ldi,
			op_stb, op_str, op_sti, op_jmp: return 1'b1;
			op_jsr:  return ~w[11]; // jsrr form
			default: return 1'b0;
		endcase
	endfunction

	task automatic check_word(input lc3b_word got, input lc3b_word exp, input string what);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("test failed");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
			$display("test failed");
			$fatal(1, "bit mismatch");
		end
	endtask

	task automatic drive_inputs();
		logic [15:0] sel, sub, hi, sr1, mode, mid, sr2, f, we, cc;
		lc3b_opcode  op;
		take_bits(4, sel);
		take_bits(2, sub);
		take_bits(3, hi);
		take_bits(2, sr1);  // r0..r3 only so fields collide often
		take_bits(1, mode);
		take_bits(2, mid);
		take_bits(2, sr2);
		take_bits(3, f);
		take_bits(2, we);
		take_bits(3, cc);
		case (sel[3:0])
			4'd0, 4'd1: op = op_ldr;
			4'd2:       op = op_ldb;
			4'd3:       op = op_ldi;
			4'd4:       op = op_br;
			4'd5:       op = op_jmp;
			4'd6:       op = op_jsr;
			4'd7:       op = op_trap;
			4'd8, 4'd9: op = op_lea;
			4'd10:      op = op_add;
			4'd11:      op = op_and;
			4'd12:      op = op_not;
			4'd13:      op = op_shf;
			4'd14:      op = op_str;
			default:    op = (sub[1:0] == 2'd1) ? op_stb : (sub[1:0] == 2'd2) ? op_sti : op_rti;
		endcase
		if (op != op_br && op != op_jsr)
			hi[2] = 1'b0; // nzp and jsr mode get the full field
		fetch_ir = {op, hi[2:0], 1'b0, sr1[1:0], mode[0], mid[1:0], 1'b0, sr2[1:0]};
		if (sel[3:0] == 4'd15 && sub[1:0] == 2'd0)
			fetch_ir = '0; // plain nop
		flow  = (f[2:0] != 3'd0); // low about 1 in 8
		cc_we = (we[1:0] == 2'd0);
		cc_in = cc[2:0];
	endtask

	task automatic predict();
		lc3b_opcode ifop, exop, lastop;
		logic       ld, xfer, lea_run;
		ifop    = lc3b_opcode'(model_ifid[15:12]);
		exop    = lc3b_opcode'(model_idex[15:12]);
		lastop  = lc3b_opcode'(model_last[15:12]);
		ld      = (exop == op_ldb || exop == op_ldr || exop == op_ldi);
		xfer    = model_ifid != '0 &&
			(ifop == op_br || ifop == op_jmp || ifop == op_jsr || ifop == op_trap);
		lea_run = (lastop == op_lea) && model_cnt != '0;
		exp_hazard = ld && ((reads_base(model_ifid) && model_ifid[8:6] == model_idex[11:9]) ||
			((ifop == op_add || ifop == op_and) && !model_ifid[5] &&
			model_ifid[2:0] == model_idex[11:9]) ||
			((ifop == op_stb || ifop == op_str || ifop == op_sti) &&
			model_ifid[11:9] == model_idex[11:9]));
		exp_bubble    = exp_hazard || model_cnt > 3'd1 || lea_run;
		exp_squash    = model_cnt == 3'd1 && (lastop != op_br || model_be_q);
		exp_be        = exop == op_br && (model_idex[11:9] & model_nzp) != '0;
		exp_start     = model_cnt == '0 && (xfer || lastop == op_lea);
		exp_hold_last = model_cnt > 3'd1 || lea_run; // decode word kept for the final slot
		if (flow)
		begin
			n_load_use += int'(exp_hazard);
			n_shadow   += int'(model_cnt == '0 && xfer);
			n_lea      += int'(model_cnt == '0 && lastop == op_lea);
		end
		else if (cc_we)
			n_frozen++; // cc write while frozen
	endtask

	// steps the model over the coming edge using the old IF/ID
	task automatic advance_model();
		if (flow)
		begin
			if (!exp_hold_last)
				model_last = model_ifid;
			if (model_cnt == SHADOW_LEN)
				model_be_q = exp_be; // transfer is in ID/EX on the first shadow cycle
			if (model_cnt != '0)
				model_cnt = model_cnt - 3'd1;
			else if (exp_start)
				model_cnt = SHADOW_LEN;
			model_idex = (exp_bubble || exp_squash) ? lc3b_word'('0) : model_ifid;
			if (!exp_bubble)
				model_ifid = fetch_ir;
		end
		if (cc_we)
			model_nzp = cc_in; // lands regardless of flow
	endtask

	initial
	begin
		lfsr_q     = 16'd22;
		rst_n      = 1'b0;
		flow       = 1'b0;
		cc_we      = 1'b0;
		cc_in      = '0;
		fetch_ir   = '0;
		model_ifid = '0;
		model_idex = '0;
		model_last = '0;
		model_cnt  = '0;
		model_be_q = 1'b0;
		model_nzp  = '0;
		n_load_use = 0;
		n_shadow   = 0;
		n_lea      = 0;
		n_frozen   = 0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		#4;
		check_word(if_id_ir, '0, "if_id_ir after reset");
		check_word(id_ex_ir, '0, "id_ex_ir after reset");
		check_bit(fetch_hold, 1'b0, "fetch_hold after reset");
		check_bit(squash_id, 1'b0, "squash_id after reset");
		@(posedge clk);
		for (int i = 0; i < NUM_CYCLES; i++)
		begin
			#1;
			drive_inputs();
			#4; // mid cycle where combinational outputs have settled
			predict();
			check_word(if_id_ir, model_ifid, "if_id_ir");
			check_word(id_ex_ir, model_idex, "id_ex_ir");
			check_bit(fetch_hold, exp_bubble, "fetch_hold");
			check_bit(squash_id, exp_squash, "squash_id");
			check_bit(uut.branch_enable, exp_be, "branch_enable");
			advance_model();
			@(posedge clk);
		end
		if (n_load_use == 0 || n_shadow == 0 || n_lea == 0 || n_frozen == 0)
		begin
			$display("random stimulus missed a scenario: load-use %0d shadow %0d lea %0d frozen %0d",
				n_load_use, n_shadow, n_lea, n_frozen);
			$display("test failed");
			$fatal(1, "scenario not exercised");
		end
		else
		begin
			$display("test passed");
			$finish;
		end
	end

endmodule : tb_hazard_pipe

`default_nettype wire

// ==== verilog.f ====
hw/lc3b_types.sv
hw/dep_decode.sv
hw/branch_eval.sv
hw/bubbler.sv
hw/stage_regs.sv
hw/hazard_pipe.sv
tb/tb_hazard_pipe.sv

// ==== Bender.yml ====
package:
  name: hazard_pipe

sources:
  - hw/lc3b_types.sv
  - hw/dep_decode.sv
  - hw/branch_eval.sv
  - hw/bubbler.sv
  - hw/stage_regs.sv
  - hw/hazard_pipe.sv
  - target: simulation
    files:
      - tb/tb_hazard_pipe.sv
